// ==== hw/ivec_isa_pkg.sv ====
// Packed-SIMD integer unit, instruction set definitions
// Holds the opcode encoding of the eight packed operations and the
// operand types that the datapaths slice into halfwords and bytes
package ivec_isa_pkg;

    // Full operand and result word
    typedef logic [31:0] word_t;

    // One halfword lane of a packed operand
    typedef logic [15:0] half_t;

    // One byte lane of a packed operand
    typedef logic [7:0] byte_t;

    // Opcode encoding of the packed operations
    // Bit pattern matches the existing core decoder, so the values are fixed
    typedef enum logic [2:0] {
        // Low halves of the two signed halfword products
        MUL_LO  = 3'd0,
        // High halves of the two signed halfword products
        MUL_HI  = 3'd1,
        // Sum of both halfword products
        MUL_DOT = 3'd2,
        // Unsigned sum of absolute byte differences
        SAD8    = 3'd3,
        // Low half of a over low half of b
        PACK_H  = 3'd4,
        // Unsigned sum of absolute halfword differences
        SAD16   = 3'd5,
        // Byte permute of a under control of b
        PERM_B  = 3'd6,
        // Low byte of a over low byte of b, upper half zero
        PACK_B  = 3'd7
    } ivec_opcode_e;

endpackage

// ==== hw/ivec_pipe_pkg.sv ====
// Packed-SIMD integer unit, pipeline definitions
// Names the two datapaths, maps each opcode to the datapath that owns it
// and defines the tag that travels with an operation to the consumer
package ivec_pipe_pkg;

    import ivec_isa_pkg::*;

    // Datapath that executes an opcode
    typedef enum logic {
        CLASS_MUL = 1'b0,
        CLASS_SAD = 1'b1
    } ivec_class_e;

    // Operation tag chosen by the issuer and returned with the result
    typedef logic [3:0] tag_t;

    // The three multiply opcodes go to the multiply datapath
    // Everything else is handled by the difference and permute datapath
    function automatic ivec_class_e ivec_class_of(ivec_opcode_e opcode);
        case (opcode)
            MUL_LO, MUL_HI, MUL_DOT: return CLASS_MUL;
            default: return CLASS_SAD;
        endcase
    endfunction

endpackage

// ==== hw/ivec_stage_if.sv ====
// Packed-SIMD integer unit, issue stage bundle
// Carries one issued operation from the top level to both datapaths
// Both datapaths see every operation and decode their own class
`timescale 1ns/100ps

interface ivec_stage_if import ivec_isa_pkg::*, ivec_pipe_pkg::*; ();

    // Operation is present this cycle
    logic         valid;
    ivec_opcode_e opcode;
    // Packed source operands
    word_t        a;
    word_t        b;
    tag_t         tag;

    // Driven by the issue side of the unit
    modport issuer (
        output valid, opcode, a, b, tag
    );

    // Read by each datapath
    modport lane (
        input valid, opcode, a, b, tag
    );

endinterface

// ==== hw/ivec_lane_if.sv ====
// Packed-SIMD integer unit, datapath result bundle
// Carries one finished result and its tag from a datapath to the queue
`timescale 1ns/100ps

interface ivec_lane_if import ivec_isa_pkg::*, ivec_pipe_pkg::*; ();

    // High for one cycle per finished operation
    logic  valid;
    word_t data;
    tag_t  tag;

    // Datapath side
    modport source (
        output valid, data, tag
    );

    // Result queue side
    modport sink (
        input valid, data, tag
    );

endinterface

// ==== hw/ivec_mul_lanes.sv ====
// Packed-SIMD integer unit, multiply datapath
// Two-stage signed 16x16 halfword multiplier for MUL_LO, MUL_HI and MUL_DOT
// Stage one forms both halfword products, stage two picks the halves
// or adds the products and drives the lane
`timescale 1ns/100ps

module ivec_mul_lanes import ivec_isa_pkg::*, ivec_pipe_pkg::*; (
    input  logic clk,
    input  logic reset,
    ivec_stage_if.lane   stage,
    ivec_lane_if.source  lane
);

    // Halfword slices of the issued operands
    half_t a_lo;
    half_t a_hi;
    half_t b_lo;
    half_t b_hi;
    logic  is_mul;

    // Full 32-bit signed products of each halfword pair
    logic signed [31:0] prod_lo;
    logic signed [31:0] prod_hi;

    // Stage one registers
    logic               s1_valid;
    ivec_opcode_e       s1_opcode;
    tag_t               s1_tag;
    logic signed [31:0] s1_prod_lo;
    logic signed [31:0] s1_prod_hi;

    // Stage two result before the output register
    word_t mul_result;

    assign a_lo = stage.a[15:0];
    assign a_hi = stage.a[31:16];
    assign b_lo = stage.b[15:0];
    assign b_hi = stage.b[31:16];

    // Only take operations that belong to this datapath
    assign is_mul = stage.valid && (ivec_class_of(stage.opcode) == CLASS_MUL);

    // Both operands are sign extended to 32 bits before the multiply
    assign prod_lo = $signed(a_lo) * $signed(b_lo);
    assign prod_hi = $signed(a_hi) * $signed(b_hi);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= is_mul;
        end
    end

    // Products, opcode and tag only load for multiply operations
    always_ff @(posedge clk) begin
        if (is_mul) begin
            s1_prod_lo <= prod_lo;
            s1_prod_hi <= prod_hi;
            s1_opcode  <= stage.opcode;
            s1_tag     <= stage.tag;
        end
    end

    // Upper halfword lane always lands in the upper half of the result
    always_comb begin
        case (s1_opcode)
            MUL_LO:  mul_result = {s1_prod_hi[15:0], s1_prod_lo[15:0]};
            MUL_HI:  mul_result = {s1_prod_hi[31:16], s1_prod_lo[31:16]};
            MUL_DOT: mul_result = word_t'(s1_prod_hi + s1_prod_lo);
            default: mul_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane.valid <= 1'b0;
        end else begin
            lane.valid <= s1_valid;
        end
    end

    // Result payload follows the stage one valid
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            lane.data <= mul_result;
            lane.tag  <= s1_tag;
        end
    end

endmodule

// ==== hw/ivec_sad_perm.sv ====
// Packed-SIMD integer unit, difference and permute datapath
// Two-stage datapath for SAD8, SAD16, PERM_B, PACK_H and PACK_B
// Stage one forms the absolute differences and the byte moves,
// stage two sums the differences or selects a move and drives the lane
`timescale 1ns/100ps

module ivec_sad_perm import ivec_isa_pkg::*, ivec_pipe_pkg::*; (
    input  logic clk,
    input  logic reset,
    ivec_stage_if.lane   stage,
    ivec_lane_if.source  lane
);

    logic  is_sad;
    byte_t byte_diff [4];
    half_t half_diff [2];
    word_t perm_word;

    // Stage one registers
    logic         s1_valid;
    ivec_opcode_e s1_opcode;
    tag_t         s1_tag;
    byte_t        s1_byte_diff [4];
    half_t        s1_half_diff [2];
    word_t        s1_perm;
    word_t        s1_pack_h;
    half_t        s1_pack_b;

    // Adder trees of stage two, wide enough to hold every carry
    logic [9:0]  sad8_sum;
    logic [16:0] sad16_sum;
    word_t       sad_result;

    // Unsigned absolute difference of two bytes
    function automatic byte_t abs_diff8(byte_t x, byte_t y);
        return (x > y) ? byte_t'(x - y) : byte_t'(y - x);
    endfunction

    // Unsigned absolute difference of two halfwords
    function automatic half_t abs_diff16(half_t x, half_t y);
        return (x > y) ? half_t'(x - y) : half_t'(y - x);
    endfunction

    assign is_sad = stage.valid && (ivec_class_of(stage.opcode) == CLASS_SAD);

    // Per-lane differences and the permute are all formed in the first stage
    always_comb begin
        byte_t sel;
        for (int i = 0; i < 4; i++) begin
            byte_diff[i] = abs_diff8(stage.a[8*i +: 8], stage.b[8*i +: 8]);
            sel = stage.b[8*i +: 8];
            // Bit 7 of a selector byte forces that result byte to zero
            perm_word[8*i +: 8] = sel[7] ? 8'd0 : stage.a[8*sel[1:0] +: 8];
        end
        for (int j = 0; j < 2; j++) begin
            half_diff[j] = abs_diff16(stage.a[16*j +: 16], stage.b[16*j +: 16]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= is_sad;
        end
    end

    always_ff @(posedge clk) begin
        if (is_sad) begin
            s1_opcode    <= stage.opcode;
            s1_tag       <= stage.tag;
            s1_byte_diff <= byte_diff;
            s1_half_diff <= half_diff;
            s1_perm      <= perm_word;
            s1_pack_h    <= {stage.a[15:0], stage.b[15:0]};
            s1_pack_b    <= {stage.a[7:0], stage.b[7:0]};
        end
    end

    // Pairwise byte sums first, then the final add
    assign sad8_sum  = 10'(9'(s1_byte_diff[0] + s1_byte_diff[1]))
                     + 10'(9'(s1_byte_diff[2] + s1_byte_diff[3]));
    assign sad16_sum = 17'(s1_half_diff[0]) + 17'(s1_half_diff[1]);

    always_comb begin
        case (s1_opcode)
            SAD8:    sad_result = {22'd0, sad8_sum};
            SAD16:   sad_result = {15'd0, sad16_sum};
            PERM_B:  sad_result = s1_perm;
            PACK_H:  sad_result = s1_pack_h;
            PACK_B:  sad_result = {16'd0, s1_pack_b};
            default: sad_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane.valid <= 1'b0;
        end else begin
            lane.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            lane.data <= sad_result;
            lane.tag  <= s1_tag;
        end
    end

endmodule

// ==== hw/ivec_result_queue.sv ====
// Packed-SIMD integer unit, result queue
// Merges the two datapath lanes into one in-order circular FIFO,
// pops an entry whenever an output credit is held, and returns one
// issue credit to the issuer for every entry that leaves
`timescale 1ns/100ps

module ivec_result_queue import ivec_isa_pkg::*, ivec_pipe_pkg::*; #(
    parameter int RESULT_DEPTH = 4,
    parameter int OUT_CREDITS  = 2
) (
    input  logic  clk,
    input  logic  reset,
    ivec_lane_if.sink mul_lane,
    ivec_lane_if.sink sad_lane,
    output logic  result_valid,
    output word_t result_data,
    output tag_t  result_tag,
    input  logic  result_credit,
    output logic  issue_credit
);

    localparam int PTR_W  = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int CNT_W  = $clog2(RESULT_DEPTH + 1);
    // One spare bit so early credit returns cannot wrap the counter
    localparam int CRED_W = $clog2(OUT_CREDITS + 1) + 1;

    word_t data_mem [RESULT_DEPTH];
    tag_t  tag_mem  [RESULT_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] out_credits;

    logic  push;
    logic  pop;
    word_t push_data;
    tag_t  push_tag;

    // Pointer advance with wrap at the last entry, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RESULT_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // The datapaths never finish in the same cycle, so a plain mux merges them
    assign push      = mul_lane.valid || sad_lane.valid;
    assign push_data = mul_lane.valid ? mul_lane.data : sad_lane.data;
    assign push_tag  = mul_lane.valid ? mul_lane.tag : sad_lane.tag;

    // An entry leaves only while the consumer has room for it
    assign pop = (count != '0) && (out_credits != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= push_data;
            tag_mem[wr_ptr]  <= push_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Consumer returns one credit per pulse, each pop spends one
    always_ff @(posedge clk) begin
        if (reset) begin
            out_credits <= CRED_W'(OUT_CREDITS);
        end else begin
            case ({result_credit, pop})
                2'b10:   out_credits <= out_credits + 1'b1;
                2'b01:   out_credits <= out_credits - 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    // The freed entry goes back to the issuer in the same cycle as the result
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            issue_credit <= 1'b0;
        end else begin
            result_valid <= pop;
            issue_credit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result_data <= data_mem[rd_ptr];
            result_tag  <= tag_mem[rd_ptr];
        end
    end

endmodule

// ==== hw/ivec_unit.sv ====
// Packed-SIMD integer unit, top level
// Accepts one operation per cycle under issue credits, runs it on the
// multiply or the difference and permute datapath, and returns results
// in issue order under output credits from the consumer
`timescale 1ns/100ps

module ivec_unit import ivec_isa_pkg::*, ivec_pipe_pkg::*; #(
    parameter int RESULT_DEPTH = 4,
    parameter int OUT_CREDITS  = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         issue_valid,
    input  ivec_opcode_e issue_opcode,
    input  word_t        issue_a,
    input  word_t        issue_b,
    input  tag_t         issue_tag,
    output logic         issue_credit,
    output logic         result_valid,
    output word_t        result_data,
    output tag_t         result_tag,
    input  logic         result_credit
);

    // Issued operation, seen by both datapaths
    ivec_stage_if stage ();

    // One result lane per datapath
    ivec_lane_if mul_lane ();
    ivec_lane_if sad_lane ();

    // The issue ports feed the stage bundle directly, there is no issue register
    assign stage.valid  = issue_valid;
    assign stage.opcode = issue_opcode;
    assign stage.a      = issue_a;
    assign stage.b      = issue_b;
    assign stage.tag    = issue_tag;

    ivec_mul_lanes i_mul_lanes (
        .clk   (clk),
        .reset (reset),
        .stage (stage.lane),
        .lane  (mul_lane.source)
    );

    ivec_sad_perm i_sad_perm (
        .clk   (clk),
        .reset (reset),
        .stage (stage.lane),
        .lane  (sad_lane.source)
    );

    ivec_result_queue #(
        .RESULT_DEPTH (RESULT_DEPTH),
        .OUT_CREDITS  (OUT_CREDITS)
    ) i_result_queue (
        .clk           (clk),
        .reset         (reset),
        .mul_lane      (mul_lane.sink),
        .sad_lane      (sad_lane.sink),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_tag    (result_tag),
        .result_credit (result_credit),
        .issue_credit  (issue_credit)
    );

endmodule

// ==== bench/ivec_clock_gen.sv ====
// Testbench clock generator for the packed-SIMD integer unit
// Free-running clock, low at time zero, with a fixed period
`timescale 1ns/100ps

module ivec_clock_gen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period high, half period low
    always #(PERIOD / 2.0) clk = ~clk;

endmodule

// ==== bench/ivec_unit_tb.sv ====
// Testbench for the packed-SIMD integer unit
// Drives random and corner operations through the issue credit handshake,
// returns or withholds output credits, and checks data, tags, order,
// latency and both credit loops against a reference model
`timescale 1ns/100ps

module ivec_unit_tb import ivec_isa_pkg::*, ivec_pipe_pkg::*; ();

    localparam int RESULT_DEPTH = 4;
    localparam int OUT_CREDITS  = 2;
    // Opcode sweep, back-to-back run, back-pressure run and interleaved run
    localparam int NUM_OPS        = 8 * 6 + 16 + (RESULT_DEPTH + OUT_CREDITS) + 16;
    localparam int TIMEOUT_CYCLES = 8 * (NUM_OPS + 50);

    // One outstanding operation as the consumer expects to see it
    typedef struct {
        word_t data;
        tag_t  tag;
        int    issue_edge;
        bit    timed;
    } expect_t;

    logic         clk;
    logic         reset;
    logic         issue_valid;
    ivec_opcode_e issue_opcode;
    word_t        issue_a;
    word_t        issue_b;
    tag_t         issue_tag;
    logic         issue_credit;
    logic         result_valid;
    word_t        result_data;
    tag_t         result_tag;
    logic         result_credit;

    expect_t     pending [$];
    int          cycle = 0;
    int          issue_credits_held = RESULT_DEPTH;
    int          out_credits_held = OUT_CREDITS;
    bit          auto_credit = 1'b1;
    tag_t        next_tag = '0;
    logic [31:0] rng_state = 32'h1179_f995;

    ivec_clock_gen #(.PERIOD(4.0)) i_clock_gen (.clk(clk));

    ivec_unit i_ivec_unit (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_opcode  (issue_opcode),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_credit  (issue_credit),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_tag    (result_tag),
        .result_credit (result_credit)
    );

    // Edge counter that also ends a run that never finishes
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected result worked out lane by lane from the operation rules
    function automatic word_t ref_result(ivec_opcode_e op, word_t a, word_t b);
        word_t p_lo;
        word_t p_hi;
        word_t shifted;
        word_t r;
        int    x;
        int    y;
        int    sum;
        p_lo = word_t'(int'($signed(a[15:0])) * int'($signed(b[15:0])));
        p_hi = word_t'(int'($signed(a[31:16])) * int'($signed(b[31:16])));
        sum = 0;
        r = '0;
        case (op)
            MUL_LO:  r = {p_hi[15:0], p_lo[15:0]};
            MUL_HI:  r = {p_hi[31:16], p_lo[31:16]};
            MUL_DOT: r = p_hi + p_lo;
            SAD8: begin
                for (int i = 0; i < 4; i++) begin
                    x = int'(a[8*i +: 8]);
                    y = int'(b[8*i +: 8]);
                    sum += (x > y) ? x - y : y - x;
                end
                r = word_t'(sum);
            end
            SAD16: begin
                for (int i = 0; i < 2; i++) begin
                    x = int'(a[16*i +: 16]);
                    y = int'(b[16*i +: 16]);
                    sum += (x > y) ? x - y : y - x;
                end
                r = word_t'(sum);
            end
            PERM_B: begin
                for (int i = 0; i < 4; i++) begin
                    shifted = a >> (8 * b[8*i +: 2]);
                    r[8*i +: 8] = b[8*i + 7] ? 8'h00 : shifted[7:0];
                end
            end
            PACK_H:  r = {a[15:0], b[15:0]};
            PACK_B:  r = {16'h0000, a[7:0], b[7:0]};
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("FAIL at %0.1f ns: %s expected 0x%08h, got 0x%08h",
                 $realtime, name, expected, actual);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic report_error(string what);
        $display("Error at %0.1f ns: %s", $realtime, what);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    // Checks the outputs of the last edge and answers the result with a credit
    task automatic observe();
        expect_t e;
        if (issue_credit) begin
            assert (result_valid)
                else report_error("issue_credit pulsed while no result left the queue");
            issue_credits_held++;
            assert (issue_credits_held <= RESULT_DEPTH)
                else report_error("more issue credits came back than were spent");
        end
        if (result_valid) begin
            assert (out_credits_held > 0)
                else report_error("result presented without an output credit");
            out_credits_held--;
            assert (pending.size() > 0)
                else report_error("result arrived with no operation outstanding");
            e = pending.pop_front();
            assert (result_data == e.data) else report_mismatch("result_data", e.data, result_data);
            assert (result_tag == e.tag) else report_mismatch("result_tag", e.tag, result_tag);
            // Three edges from issue to result when nothing older waits
            if (e.timed) begin
                assert (cycle - e.issue_edge == 3)
                    else report_mismatch("result latency", 3, cycle - e.issue_edge);
            end
        end
        result_credit = auto_credit && result_valid;
        if (result_credit) begin
            out_credits_held++;
        end
    endtask

    // Inputs change half a nanosecond after the edge when the outputs have settled
    task automatic step();
        @(posedge clk);
        #0.5;
        observe();
    endtask

    task automatic issue_op(ivec_opcode_e op, word_t a, word_t b, bit timed);
        expect_t e;
        while (issue_credits_held == 0) begin
            step();
        end
        e.data = ref_result(op, a, b);
        e.tag = next_tag;
        e.issue_edge = cycle + 1;
        e.timed = timed;
        pending.push_back(e);
        issue_valid = 1'b1;
        issue_opcode = op;
        issue_a = a;
        issue_b = b;
        issue_tag = next_tag;
        next_tag++;
        issue_credits_held--;
        step();
        issue_valid = 1'b0;
    endtask

    task automatic grant_credit();
        result_credit = 1'b1;
        out_credits_held++;
        step();
    endtask

    // Two extra edges let the last returned credit reach the queue
    task automatic drain();
        while (pending.size() != 0) begin
            step();
        end
        repeat (2) step();
    endtask

    initial begin
        word_t a;
        word_t b;
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_opcode = MUL_LO;
        issue_a = '0;
        issue_b = '0;
        issue_tag = '0;
        result_credit = 1'b0;
        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b0;

        // Quiet outputs after reset
        repeat (5) begin
            step();
            assert (result_valid == 1'b0) else report_mismatch("result_valid", 0, result_valid);
            assert (issue_credit == 1'b0) else report_mismatch("issue_credit", 0, issue_credit);
        end

        // Every opcode with random operands and the corner cases
        for (int op = 0; op < 8; op++) begin
            for (int kind = 0; kind < 6; kind++) begin
                a = next_random();
                b = next_random();
                if (kind == 3) begin
                    a = 32'h8000_8000;
                    b = 32'h8000_8000;
                end else if (kind == 4) begin
                    b = a;
                end else if (kind == 5) begin
                    b = b | 32'h8000_8000;
                end
                issue_op(ivec_opcode_e'(op), a, b, 1'b0);
            end
        end
        drain();

        // Back-to-back issue into an empty queue with prompt credit returns
        for (int i = 0; i < 16; i++) begin
            issue_op(ivec_opcode_e'(next_random() % 8), next_random(), next_random(), 1'b1);
        end
        drain();

        // Consumer holds its credits until the queue and the issuer are full
        auto_credit = 1'b0;
        for (int i = 0; i < RESULT_DEPTH + OUT_CREDITS; i++) begin
            issue_op(ivec_opcode_e'(next_random() % 8), next_random(), next_random(), 1'b0);
        end
        repeat (12) begin
            step();
            assert (issue_credit == 1'b0) else report_mismatch("issue_credit", 0, issue_credit);
        end
        // Every withheld credit comes back one at a time and every held result must leave
        for (int i = 0; i < RESULT_DEPTH + OUT_CREDITS; i++) begin
            grant_credit();
            repeat (2) step();
        end
        auto_credit = 1'b1;
        drain();

        // Multiply and difference opcodes alternate so both datapaths overlap
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 0) begin
                issue_op(ivec_opcode_e'((i / 2) % 3), next_random(), next_random(), 1'b1);
            end else begin
                issue_op(ivec_opcode_e'(3 + (i / 2) % 5), next_random(), next_random(), 1'b1);
            end
        end
        drain();

        assert (issue_credits_held == RESULT_DEPTH)
            else report_mismatch("issue credits held", RESULT_DEPTH, issue_credits_held);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/ivec_isa_pkg.sv
hw/ivec_pipe_pkg.sv
hw/ivec_stage_if.sv
hw/ivec_lane_if.sv
hw/ivec_mul_lanes.sv
hw/ivec_sad_perm.sv
hw/ivec_result_queue.sv
hw/ivec_unit.sv
bench/ivec_clock_gen.sv
bench/ivec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: ivec_unit

sources:
  - hw/ivec_isa_pkg.sv
  - hw/ivec_pipe_pkg.sv
  - hw/ivec_stage_if.sv
  - hw/ivec_lane_if.sv
  - hw/ivec_mul_lanes.sv
  - hw/ivec_sad_perm.sv
  - hw/ivec_result_queue.sv
  - hw/ivec_unit.sv
  - target: simulation
    files:
      - bench/ivec_clock_gen.sv
      - bench/ivec_unit_tb.sv
